// ==== design/cpuCtrlPkg.sv ====
`default_nettype none

package cpuCtrlPkg;

    localparam int OpcodeWidth = 4;
    localparam int FuncWidth = 6;

    localparam logic [OpcodeWidth-1:0] OpBne = 4'd0;
    localparam logic [OpcodeWidth-1:0] OpBeq = 4'd1;
    localparam logic [OpcodeWidth-1:0] OpBgz = 4'd2;
    localparam logic [OpcodeWidth-1:0] OpBlz = 4'd3;
    localparam logic [OpcodeWidth-1:0] OpAdi = 4'd4;
    localparam logic [OpcodeWidth-1:0] OpOri = 4'd5;
    localparam logic [OpcodeWidth-1:0] OpLhi = 4'd6;
    localparam logic [OpcodeWidth-1:0] OpLwd = 4'd7;
    localparam logic [OpcodeWidth-1:0] OpSwd = 4'd8;
    localparam logic [OpcodeWidth-1:0] OpJmp = 4'd9;
    localparam logic [OpcodeWidth-1:0] OpJal = 4'd10;
    localparam logic [OpcodeWidth-1:0] OpAlu = 4'd15; // r-type, func selects

    localparam logic [FuncWidth-1:0] FnAdd = 6'd0;
    localparam logic [FuncWidth-1:0] FnSub = 6'd1;
    localparam logic [FuncWidth-1:0] FnAnd = 6'd2;
    localparam logic [FuncWidth-1:0] FnOrr = 6'd3;
    localparam logic [FuncWidth-1:0] FnNot = 6'd4;
    localparam logic [FuncWidth-1:0] FnTcp = 6'd5;
    localparam logic [FuncWidth-1:0] FnShl = 6'd6;
    localparam logic [FuncWidth-1:0] FnShr = 6'd7;
    localparam logic [FuncWidth-1:0] FnJpr = 6'd25;
    localparam logic [FuncWidth-1:0] FnJrl = 6'd26;
    localparam logic [FuncWidth-1:0] FnWwd = 6'd28; // decoded as no-op
    localparam logic [FuncWidth-1:0] FnHlt = 6'd29;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOrr, AluNot, AluTcp, AluShl, AluShr,
        AluLhi, AluBne, AluBeq, AluBgz, AluBlz
    } aluOp_t;

    typedef enum logic [3:0] {
        ClsAlu, ClsAluImm, ClsLoad, ClsStore, ClsBranch, ClsJump, ClsJumpLink,
        ClsJumpReg, ClsJumpRegLink, ClsHalt, ClsNop
    } instClass_t;

    typedef enum logic [2:0] {
        StFetch, StFetchRelease, StDecode, StExecute, StMem, StMemRelease,
        StWriteBack, StHalted
    } stage_t;

    typedef enum logic [1:0] {SrcBReg, SrcBOne, SrcBImm, SrcBZero} srcB_t;

    typedef enum logic [1:0] {ImmNone, ImmSigned8, ImmTarget12} immSel_t;

    typedef enum logic [1:0] {DstRt, DstRd, DstLink} regDst_t;

    typedef enum logic [1:0] {SrcAluOut, SrcMem, SrcPc} regSrc_t;

    typedef enum logic {PcFromAlu, PcFromAluOut} pcSrc_t;

    typedef struct packed {
        instClass_t cls;
        aluOp_t     aluOp;
        srcB_t      srcB;
        logic       srcAReg; // 1 = register a, 0 = pc
        immSel_t    immSel;
        regDst_t    regDst;
    } decodedInst_t;

    typedef struct packed {
        logic       pcWrite;
        logic       pcWriteCond;
        logic       irWrite;
        logic       mdrWrite;
        logic       aluOutWrite;
        logic       regWrite;
        logic       iorD; // 1 = data address from aluOut
        pcSrc_t     pcSrc;
        aluOp_t     aluOp;
        logic       srcAReg;
        srcB_t      srcB;
        immSel_t    immSel;
        regDst_t    regDst;
        regSrc_t    regSrc;
    } ctrlWord_t;

endpackage

`default_nettype wire

// ==== design/instDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
    input  logic [cpuCtrlPkg::OpcodeWidth-1:0] opcode,
    input  logic [cpuCtrlPkg::FuncWidth-1:0]   func,
    output cpuCtrlPkg::decodedInst_t           dec
);

    always_comb
    begin
        dec.cls = cpuCtrlPkg::ClsNop; // wwd and unknown codes
        dec.aluOp = cpuCtrlPkg::AluAdd;
        dec.srcB = cpuCtrlPkg::SrcBReg;
        dec.srcAReg = 1'b1;
        dec.immSel = cpuCtrlPkg::ImmNone;
        dec.regDst = cpuCtrlPkg::DstRt;

        case (opcode)
            cpuCtrlPkg::OpAlu:
            begin
                dec.regDst = cpuCtrlPkg::DstRd;
                case (func)
                    cpuCtrlPkg::FnAdd: dec.cls = cpuCtrlPkg::ClsAlu;
                    cpuCtrlPkg::FnSub:
                    begin
                        dec.cls = cpuCtrlPkg::ClsAlu;
                        dec.aluOp = cpuCtrlPkg::AluSub;
                    end
                    cpuCtrlPkg::FnAnd:
                    begin
                        dec.cls = cpuCtrlPkg::ClsAlu;
                        dec.aluOp = cpuCtrlPkg::AluAnd;
                    end
                    cpuCtrlPkg::FnOrr:
                    begin
                        dec.cls = cpuCtrlPkg::ClsAlu;
                        dec.aluOp = cpuCtrlPkg::AluOrr;
                    end
                    cpuCtrlPkg::FnNot:
                    begin
                        dec.cls = cpuCtrlPkg::ClsAlu;
                        dec.aluOp = cpuCtrlPkg::AluNot;
                    end
                    cpuCtrlPkg::FnTcp:
                    begin
                        dec.cls = cpuCtrlPkg::ClsAlu;
                        dec.aluOp = cpuCtrlPkg::AluTcp;
                    end
                    cpuCtrlPkg::FnShl:
                    begin
                        dec.cls = cpuCtrlPkg::ClsAlu;
                        dec.aluOp = cpuCtrlPkg::AluShl;
                        dec.srcB = cpuCtrlPkg::SrcBOne; // shift by one
                    end
                    cpuCtrlPkg::FnShr:
                    begin
                        dec.cls = cpuCtrlPkg::ClsAlu;
                        dec.aluOp = cpuCtrlPkg::AluShr;
                        dec.srcB = cpuCtrlPkg::SrcBOne;
                    end
                    cpuCtrlPkg::FnJpr:
                    begin
                        dec.cls = cpuCtrlPkg::ClsJumpReg;
                        dec.srcB = cpuCtrlPkg::SrcBZero; // target = rs + 0
                    end
                    cpuCtrlPkg::FnJrl:
                    begin
                        dec.cls = cpuCtrlPkg::ClsJumpRegLink;
                        dec.srcB = cpuCtrlPkg::SrcBZero;
                        dec.regDst = cpuCtrlPkg::DstLink;
                    end
                    cpuCtrlPkg::FnHlt: dec.cls = cpuCtrlPkg::ClsHalt;
                    default: dec.regDst = cpuCtrlPkg::DstRt;
                endcase
            end
            cpuCtrlPkg::OpAdi, cpuCtrlPkg::OpOri, cpuCtrlPkg::OpLhi:
            begin
                dec.cls = cpuCtrlPkg::ClsAluImm;
                dec.srcB = cpuCtrlPkg::SrcBImm;
                dec.immSel = cpuCtrlPkg::ImmSigned8;
                if (opcode == cpuCtrlPkg::OpOri)
                    dec.aluOp = cpuCtrlPkg::AluOrr;
                else if (opcode == cpuCtrlPkg::OpLhi)
                    dec.aluOp = cpuCtrlPkg::AluLhi;
            end
            cpuCtrlPkg::OpLwd, cpuCtrlPkg::OpSwd:
            begin
                dec.cls = (opcode == cpuCtrlPkg::OpLwd) ? cpuCtrlPkg::ClsLoad
                                                        : cpuCtrlPkg::ClsStore;
                dec.srcB = cpuCtrlPkg::SrcBImm; // base + offset
                dec.immSel = cpuCtrlPkg::ImmSigned8;
            end
            cpuCtrlPkg::OpBne, cpuCtrlPkg::OpBeq:
            begin
                dec.cls = cpuCtrlPkg::ClsBranch;
                dec.aluOp = (opcode == cpuCtrlPkg::OpBne) ? cpuCtrlPkg::AluBne
                                                          : cpuCtrlPkg::AluBeq;
                dec.immSel = cpuCtrlPkg::ImmSigned8;
            end
            cpuCtrlPkg::OpBgz, cpuCtrlPkg::OpBlz:
            begin
                dec.cls = cpuCtrlPkg::ClsBranch;
                dec.aluOp = (opcode == cpuCtrlPkg::OpBgz) ? cpuCtrlPkg::AluBgz
                                                          : cpuCtrlPkg::AluBlz;
                dec.srcB = cpuCtrlPkg::SrcBZero; // compare with zero
                dec.immSel = cpuCtrlPkg::ImmSigned8;
            end
            cpuCtrlPkg::OpJmp, cpuCtrlPkg::OpJal:
            begin
                dec.cls = (opcode == cpuCtrlPkg::OpJmp) ? cpuCtrlPkg::ClsJump
                                                        : cpuCtrlPkg::ClsJumpLink;
                dec.srcAReg = 1'b0; // target built from pc high bits
                dec.srcB = cpuCtrlPkg::SrcBImm;
                dec.immSel = cpuCtrlPkg::ImmTarget12;
                dec.regDst = (opcode == cpuCtrlPkg::OpJal) ? cpuCtrlPkg::DstLink
                                                           : cpuCtrlPkg::DstRt;
            end
            default: dec.cls = cpuCtrlPkg::ClsNop;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/stageSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module stageSequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  cpuCtrlPkg::decodedInst_t dec,
    input  logic                     memAck,
    output cpuCtrlPkg::stage_t       stage,
    output logic                     memReq,
    output logic                     memWe
);

    cpuCtrlPkg::stage_t nextStage;

    always_comb
    begin
        nextStage = stage; // hold by default
        case (stage)
            cpuCtrlPkg::StFetch:
            begin
                if (memAck)
                    nextStage = cpuCtrlPkg::StFetchRelease;
            end
            cpuCtrlPkg::StFetchRelease:
            begin
                if (!memAck)
                    nextStage = cpuCtrlPkg::StDecode;
            end
            cpuCtrlPkg::StDecode:
            begin
                if (dec.cls == cpuCtrlPkg::ClsHalt)
                    nextStage = cpuCtrlPkg::StHalted;
                else
                    nextStage = cpuCtrlPkg::StExecute;
            end
            cpuCtrlPkg::StExecute:
            begin
                case (dec.cls)
                    cpuCtrlPkg::ClsAlu, cpuCtrlPkg::ClsAluImm,
                    cpuCtrlPkg::ClsJumpLink, cpuCtrlPkg::ClsJumpRegLink:
                        nextStage = cpuCtrlPkg::StWriteBack;
                    cpuCtrlPkg::ClsLoad, cpuCtrlPkg::ClsStore:
                        nextStage = cpuCtrlPkg::StMem;
                    default:
                        nextStage = cpuCtrlPkg::StFetch; // branch, jump, no-op
                endcase
            end
            cpuCtrlPkg::StMem:
            begin
                if (memAck)
                    nextStage = cpuCtrlPkg::StMemRelease;
            end
            cpuCtrlPkg::StMemRelease:
            begin
                if (!memAck)
                begin
                    if (dec.cls == cpuCtrlPkg::ClsLoad)
                        nextStage = cpuCtrlPkg::StWriteBack;
                    else
                        nextStage = cpuCtrlPkg::StFetch;
                end
            end
            cpuCtrlPkg::StWriteBack: nextStage = cpuCtrlPkg::StFetch;
            default: nextStage = cpuCtrlPkg::StHalted; // parked until rst
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            stage <= cpuCtrlPkg::StFetch;
        else
            stage <= nextStage;
    end

    // request lives exactly in the two access stages
    assign memReq = (stage == cpuCtrlPkg::StFetch) || (stage == cpuCtrlPkg::StMem);
    assign memWe = (stage == cpuCtrlPkg::StMem) && (dec.cls == cpuCtrlPkg::ClsStore);

    reqRiseAckLow: assert property (
        @(posedge clk) disable iff (rst)
        $rose(memReq) |-> !memAck
    ) else $error("memReq rose while memAck high");

    reqHoldUntilAck: assert property (
        @(posedge clk) disable iff (rst)
        memReq && !memAck |=> memReq && $stable(memWe)
    ) else $error("memReq dropped or memWe changed before memAck");

    haltIsFinal: assert property (
        @(posedge clk) disable iff (rst)
        stage == cpuCtrlPkg::StHalted |=> stage == cpuCtrlPkg::StHalted
    ) else $error("halted stage left without reset");

endmodule

`default_nettype wire

// ==== design/ctrlSignalGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlSignalGen (
    input  cpuCtrlPkg::stage_t       stage,
    input  cpuCtrlPkg::decodedInst_t dec,
    input  logic                     memAck,
    output cpuCtrlPkg::ctrlWord_t    ctrl
);

    logic isLink;

    assign isLink = (dec.cls == cpuCtrlPkg::ClsJumpLink) ||
                    (dec.cls == cpuCtrlPkg::ClsJumpRegLink);

    always_comb
    begin
        ctrl.pcWrite = 1'b0;
        ctrl.pcWriteCond = 1'b0;
        ctrl.irWrite = 1'b0;
        ctrl.mdrWrite = 1'b0;
        ctrl.aluOutWrite = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.iorD = 1'b0;
        ctrl.pcSrc = cpuCtrlPkg::PcFromAlu;
        ctrl.aluOp = cpuCtrlPkg::AluAdd; // pc + 1 unless overridden
        ctrl.srcAReg = 1'b0;
        ctrl.srcB = cpuCtrlPkg::SrcBOne;
        ctrl.immSel = cpuCtrlPkg::ImmNone;
        ctrl.regDst = cpuCtrlPkg::DstRt;
        ctrl.regSrc = cpuCtrlPkg::SrcAluOut;

        case (stage)
            cpuCtrlPkg::StFetch:
            begin
                ctrl.irWrite = memAck; // latch word in ack cycle
            end
            cpuCtrlPkg::StFetchRelease:
            begin
                ctrl.pcWrite = !memAck; // pc + 1 once memory lets go
            end
            cpuCtrlPkg::StDecode:
            begin
                ctrl.srcB = cpuCtrlPkg::SrcBImm; // branch target pc + imm
                ctrl.immSel = cpuCtrlPkg::ImmSigned8;
                ctrl.aluOutWrite = 1'b1;
            end
            cpuCtrlPkg::StExecute:
            begin
                ctrl.aluOp = dec.aluOp;
                ctrl.srcAReg = dec.srcAReg;
                ctrl.srcB = dec.srcB;
                ctrl.immSel = dec.immSel;
                case (dec.cls)
                    cpuCtrlPkg::ClsAlu, cpuCtrlPkg::ClsAluImm,
                    cpuCtrlPkg::ClsLoad, cpuCtrlPkg::ClsStore:
                        ctrl.aluOutWrite = 1'b1;
                    cpuCtrlPkg::ClsBranch:
                    begin
                        ctrl.pcWriteCond = 1'b1; // alu compare gates the write
                        ctrl.pcSrc = cpuCtrlPkg::PcFromAluOut;
                    end
                    cpuCtrlPkg::ClsJump, cpuCtrlPkg::ClsJumpReg:
                        ctrl.pcWrite = 1'b1;
                    default:
                        ctrl.pcSrc = cpuCtrlPkg::PcFromAlu;
                endcase
            end
            cpuCtrlPkg::StMem:
            begin
                ctrl.iorD = 1'b1;
                ctrl.mdrWrite = memAck && (dec.cls == cpuCtrlPkg::ClsLoad);
            end
            cpuCtrlPkg::StMemRelease:
            begin
                ctrl.iorD = 1'b1; // address held through release
            end
            cpuCtrlPkg::StWriteBack:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst = dec.regDst;
                if (dec.cls == cpuCtrlPkg::ClsLoad)
                    ctrl.regSrc = cpuCtrlPkg::SrcMem;
                else if (isLink)
                begin
                    // old pc goes to the link register while pc takes the target
                    ctrl.regSrc = cpuCtrlPkg::SrcPc;
                    ctrl.pcWrite = 1'b1;
                    ctrl.aluOp = dec.aluOp;
                    ctrl.srcAReg = dec.srcAReg;
                    ctrl.srcB = dec.srcB;
                    ctrl.immSel = dec.immSel;
                end
            end
            default:
                ctrl.srcB = cpuCtrlPkg::SrcBOne; // halted, nothing written
        endcase
    end

    always_comb
    begin
        pcWriteExclusive: assert final (!(ctrl.pcWrite && ctrl.pcWriteCond))
            else $error("pcWrite and pcWriteCond both high");
        irWriteInFetch: assert final (!ctrl.irWrite || stage == cpuCtrlPkg::StFetch)
            else $error("irWrite outside fetch");
    end

endmodule

`default_nettype wire

// ==== design/cpuControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuControl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [cpuCtrlPkg::OpcodeWidth-1:0] opcode,
    input  logic [cpuCtrlPkg::FuncWidth-1:0]   func,
    input  logic                               memAck,
    output cpuCtrlPkg::ctrlWord_t              ctrl,
    output logic                               memReq,
    output logic                               memWe
);

    cpuCtrlPkg::decodedInst_t dec;
    cpuCtrlPkg::stage_t       stage;

    instDecoder decoder (
        .opcode (opcode),
        .func   (func),
        .dec    (dec)
    );

    stageSequencer sequencer (
        .clk    (clk),
        .rst    (rst),
        .dec    (dec),
        .memAck (memAck),
        .stage  (stage),
        .memReq (memReq),
        .memWe  (memWe)
    );

    ctrlSignalGen signalGen (
        .stage  (stage),
        .dec    (dec),
        .memAck (memAck),
        .ctrl   (ctrl)
    );

endmodule

`default_nettype wire

// ==== testbench/cpuControlChecks.svh ====
// four-phase handshake
reqRisesWithAckLow: assert property (
    @(posedge clk) disable iff (rst)
    $rose(memReq) |-> !memAck
) else reportFailure($sformatf("** Error: memAck = 0x%h as memReq rose, expected 0x0",
                               $sampled(memAck)));

reqHeldUntilAck: assert property (
    @(posedge clk) disable iff (rst)
    memReq && !memAck |=> memReq
) else reportFailure($sformatf("** Error: memReq = 0x%h before memAck, expected 0x1",
                               $sampled(memReq)));

weOnlyForStore: assert property (
    @(posedge clk) disable iff (rst)
    memWe |-> memReq && curCls == cpuCtrlPkg::ClsStore
) else reportFailure($sformatf("** Error: memWe = 0x1 with memReq = 0x%h, class = 0x%h",
                               $sampled(memReq), $sampled(curCls)));

// fetches address by pc, data accesses by aluOut
accessAddrSel: assert property (
    @(posedge clk) disable iff (rst)
    memReq |-> ctrl.iorD == dataPending &&
               memWe == (dataPending && curCls == cpuCtrlPkg::ClsStore)
) else reportFailure($sformatf("** Error: ctrl.iorD = 0x%h memWe = 0x%h, expected 0x%h 0x%h",
                               $sampled(ctrl.iorD), $sampled(memWe), $sampled(dataPending),
                               $sampled(dataPending && curCls == cpuCtrlPkg::ClsStore)));

// fetch order
singleIrWrite: assert property (
    @(posedge clk) disable iff (rst)
    ctrl.irWrite |=> !ctrl.irWrite
) else reportFailure("** Error: ctrl.irWrite = 0x1 in two cycles in a row, expected 0x0");

fetchAfterPcInc: assert property (
    @(posedge clk) disable iff (rst)
    ctrl.irWrite |-> !awaitPcInc
) else reportFailure("a new instruction was fetched before the PC increment");

pcIncFirst: assert property (
    @(posedge clk) disable iff (rst)
    awaitPcInc && writeEn != 6'b0 |-> writeEn == 6'b100000 &&
                                       ctrl.pcSrc == cpuCtrlPkg::PcFromAlu
) else reportFailure($sformatf("** Error: write enables = 0x%h pcSrc = 0x%h, expected 0x20 0x0",
                               $sampled(writeEn), $sampled(ctrl.pcSrc)));

// execute and write-back
execAluOp: assert property (
    @(posedge clk) disable iff (rst)
    ctrl.aluOutWrite && aluOutCount == 1 |-> ctrl.aluOp == curAluOp
) else reportFailure($sformatf("** Error: ctrl.aluOp = 0x%h, expected 0x%h",
                               $sampled(ctrl.aluOp), $sampled(curAluOp)));

aluWriteBack: assert property (
    @(posedge clk) disable iff (rst)
    ctrl.regWrite && (curCls == cpuCtrlPkg::ClsAlu || curCls == cpuCtrlPkg::ClsAluImm) |->
        ctrl.regSrc == cpuCtrlPkg::SrcAluOut &&
        ctrl.regDst == ((curCls == cpuCtrlPkg::ClsAlu) ? cpuCtrlPkg::DstRd : cpuCtrlPkg::DstRt)
) else reportFailure($sformatf("** Error: ctrl.regSrc = 0x%h ctrl.regDst = 0x%h, class = 0x%h",
                               $sampled(ctrl.regSrc), $sampled(ctrl.regDst), $sampled(curCls)));

loadWriteBack: assert property (
    @(posedge clk) disable iff (rst)
    ctrl.regWrite && curCls == cpuCtrlPkg::ClsLoad |->
        ctrl.regSrc == cpuCtrlPkg::SrcMem && mdrCount == 1
) else reportFailure($sformatf("** Error: ctrl.regSrc = 0x%h mdrWrite count = 0x%h, expected 0x1 0x1",
                               $sampled(ctrl.regSrc), $sampled(mdrCount)));

linkWriteBack: assert property (
    @(posedge clk) disable iff (rst)
    ctrl.regWrite && isLinkCls |-> ctrl.regSrc == cpuCtrlPkg::SrcPc &&
                                   ctrl.regDst == cpuCtrlPkg::DstLink && ctrl.pcWrite
) else reportFailure($sformatf("** Error: ctrl.regSrc = 0x%h ctrl.regDst = 0x%h ctrl.pcWrite = 0x%h",
                               $sampled(ctrl.regSrc), $sampled(ctrl.regDst), $sampled(ctrl.pcWrite)));

branchOnlyCond: assert property (
    @(posedge clk) disable iff (rst)
    ctrl.pcWriteCond |-> curCls == cpuCtrlPkg::ClsBranch &&
                         ctrl.pcSrc == cpuCtrlPkg::PcFromAluOut
) else reportFailure($sformatf("** Error: ctrl.pcWriteCond = 0x1 with class = 0x%h pcSrc = 0x%h",
                               $sampled(curCls), $sampled(ctrl.pcSrc)));

// per-instruction totals, checked when the next word is fetched
eventCounts: assert property (
    @(posedge clk) disable iff (rst)
    ctrl.irWrite && issued > 0 |-> regWriteCount == int'(expRegWr) &&
                                   mdrCount == int'(expMdr) && condCount == int'(expCond)
) else reportFailure($sformatf("** Error: regWrite/mdrWrite/pcWriteCond counts = 0x%h 0x%h 0x%h",
                               $sampled(regWriteCount), $sampled(mdrCount), $sampled(condCount)));

haltStaysIdle: assert property (
    @(posedge clk) disable iff (rst)
    curCls == cpuCtrlPkg::ClsHalt && aluOutCount == 1 |-> !memReq && writeEn == 6'b0
) else reportFailure($sformatf("** Error: after halt memReq = 0x%h write enables = 0x%h",
                               $sampled(memReq), $sampled(writeEn)));

// ==== testbench/cpuControlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuControlTb;

    localparam int NumInsts = 200;
    localparam int TimeoutCycles = NumInsts * 30;
    localparam int HaltWatchCycles = 50;
    localparam int MaxKinds = 24;
    localparam logic [cpuCtrlPkg::FuncWidth-1:0] NoFunc = 6'h2a; // ignored outside r-type

    logic clk = 1'b0;
    logic rst;
    logic [cpuCtrlPkg::OpcodeWidth-1:0] opcode;
    logic [cpuCtrlPkg::FuncWidth-1:0] func;
    logic memAck;
    cpuCtrlPkg::ctrlWord_t ctrl;
    logic memReq;
    logic memWe;

    // instruction kinds with the decode expected from the instruction set rules
    logic [cpuCtrlPkg::OpcodeWidth-1:0] kindOp [MaxKinds];
    logic [cpuCtrlPkg::FuncWidth-1:0] kindFn [MaxKinds];
    cpuCtrlPkg::instClass_t kindCls [MaxKinds];
    cpuCtrlPkg::aluOp_t kindAlu [MaxKinds];
    int numKinds = 0;
    int progKind [NumInsts]; // program as kind indices

    // reference model state
    cpuCtrlPkg::instClass_t curCls;
    cpuCtrlPkg::aluOp_t curAluOp;
    logic awaitPcInc;
    logic dataPending; // load or store access still to come
    int aluOutCount;
    int regWriteCount;
    int mdrCount;
    int condCount;
    int issued;
    int haltIdle;
    int cycleCount = 0;
    int ackDelay;

    logic [5:0] writeEn;
    logic isLinkCls;
    logic expRegWr;
    logic expMdr;
    logic expCond;

    assign writeEn = {ctrl.pcWrite, ctrl.pcWriteCond, ctrl.irWrite,
                      ctrl.mdrWrite, ctrl.aluOutWrite, ctrl.regWrite};
    assign isLinkCls = (curCls == cpuCtrlPkg::ClsJumpLink) ||
                       (curCls == cpuCtrlPkg::ClsJumpRegLink);
    assign expRegWr = (curCls == cpuCtrlPkg::ClsAlu) || (curCls == cpuCtrlPkg::ClsAluImm) ||
                      (curCls == cpuCtrlPkg::ClsLoad) || isLinkCls;
    assign expMdr = (curCls == cpuCtrlPkg::ClsLoad);
    assign expCond = (curCls == cpuCtrlPkg::ClsBranch);

    cpuControl dut0 (
        .clk    (clk),
        .rst    (rst),
        .opcode (opcode),
        .func   (func),
        .memAck (memAck),
        .ctrl   (ctrl),
        .memReq (memReq),
        .memWe  (memWe)
    );

    always #4 clk = ~clk;

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic addKind(
        input logic [cpuCtrlPkg::OpcodeWidth-1:0] op,
        input logic [cpuCtrlPkg::FuncWidth-1:0]   fn,
        input cpuCtrlPkg::instClass_t             cls,
        input cpuCtrlPkg::aluOp_t                 alu
    );
        kindOp[numKinds] = op;
        kindFn[numKinds] = fn;
        kindCls[numKinds] = cls;
        kindAlu[numKinds] = alu;
        numKinds = numKinds + 1;
    endtask

    task automatic fillKindTable();
        addKind(cpuCtrlPkg::OpAlu, cpuCtrlPkg::FnAdd, cpuCtrlPkg::ClsAlu, cpuCtrlPkg::AluAdd);
        addKind(cpuCtrlPkg::OpAlu, cpuCtrlPkg::FnSub, cpuCtrlPkg::ClsAlu, cpuCtrlPkg::AluSub);
        addKind(cpuCtrlPkg::OpAlu, cpuCtrlPkg::FnAnd, cpuCtrlPkg::ClsAlu, cpuCtrlPkg::AluAnd);
        addKind(cpuCtrlPkg::OpAlu, cpuCtrlPkg::FnOrr, cpuCtrlPkg::ClsAlu, cpuCtrlPkg::AluOrr);
        addKind(cpuCtrlPkg::OpAlu, cpuCtrlPkg::FnNot, cpuCtrlPkg::ClsAlu, cpuCtrlPkg::AluNot);
        addKind(cpuCtrlPkg::OpAlu, cpuCtrlPkg::FnTcp, cpuCtrlPkg::ClsAlu, cpuCtrlPkg::AluTcp);
        addKind(cpuCtrlPkg::OpAlu, cpuCtrlPkg::FnShl, cpuCtrlPkg::ClsAlu, cpuCtrlPkg::AluShl);
        addKind(cpuCtrlPkg::OpAlu, cpuCtrlPkg::FnShr, cpuCtrlPkg::ClsAlu, cpuCtrlPkg::AluShr);
        addKind(cpuCtrlPkg::OpAdi, NoFunc, cpuCtrlPkg::ClsAluImm, cpuCtrlPkg::AluAdd);
        addKind(cpuCtrlPkg::OpOri, NoFunc, cpuCtrlPkg::ClsAluImm, cpuCtrlPkg::AluOrr);
        addKind(cpuCtrlPkg::OpLhi, NoFunc, cpuCtrlPkg::ClsAluImm, cpuCtrlPkg::AluLhi);
        addKind(cpuCtrlPkg::OpLwd, NoFunc, cpuCtrlPkg::ClsLoad, cpuCtrlPkg::AluAdd);
        addKind(cpuCtrlPkg::OpSwd, NoFunc, cpuCtrlPkg::ClsStore, cpuCtrlPkg::AluAdd);
        addKind(cpuCtrlPkg::OpBne, NoFunc, cpuCtrlPkg::ClsBranch, cpuCtrlPkg::AluBne);
        addKind(cpuCtrlPkg::OpBeq, NoFunc, cpuCtrlPkg::ClsBranch, cpuCtrlPkg::AluBeq);
        addKind(cpuCtrlPkg::OpBgz, NoFunc, cpuCtrlPkg::ClsBranch, cpuCtrlPkg::AluBgz);
        addKind(cpuCtrlPkg::OpBlz, NoFunc, cpuCtrlPkg::ClsBranch, cpuCtrlPkg::AluBlz);
        addKind(cpuCtrlPkg::OpJmp, NoFunc, cpuCtrlPkg::ClsJump, cpuCtrlPkg::AluAdd);
        addKind(cpuCtrlPkg::OpJal, NoFunc, cpuCtrlPkg::ClsJumpLink, cpuCtrlPkg::AluAdd);
        addKind(cpuCtrlPkg::OpAlu, cpuCtrlPkg::FnJpr, cpuCtrlPkg::ClsJumpReg,
                cpuCtrlPkg::AluAdd);
        addKind(cpuCtrlPkg::OpAlu, cpuCtrlPkg::FnJrl, cpuCtrlPkg::ClsJumpRegLink,
                cpuCtrlPkg::AluAdd);
        addKind(cpuCtrlPkg::OpAlu, cpuCtrlPkg::FnWwd, cpuCtrlPkg::ClsNop, cpuCtrlPkg::AluAdd);
        addKind(cpuCtrlPkg::OpAlu, cpuCtrlPkg::FnHlt, cpuCtrlPkg::ClsHalt, cpuCtrlPkg::AluAdd);
    endtask

    task automatic composeProgram();
        int haltKind;
        haltKind = numKinds - 1; // hlt is the last kind
        for (int i = 0; i < NumInsts - 1; i++)
        begin
            if (i < haltKind)
                progKind[i] = i; // every kind once up front
            else
                progKind[i] = $urandom % haltKind;
        end
        progKind[NumInsts-1] = haltKind;
    endtask

    // memory with random latency in both handshake phases
    always @(posedge clk)
    begin
        if (rst)
        begin
            memAck <= 1'b0;
            ackDelay <= 0;
        end
        else if (memReq != memAck)
        begin
            if (ackDelay == 0)
            begin
                memAck <= memReq; // follow the request edge
                ackDelay <= $urandom % 4;
            end
            else
                ackDelay <= ackDelay - 1;
        end
    end

    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    always @(posedge clk)
    begin
        if (rst)
        begin
            curCls <= cpuCtrlPkg::ClsNop;
            curAluOp <= cpuCtrlPkg::AluAdd;
            awaitPcInc <= 1'b0;
            dataPending <= 1'b0;
            aluOutCount <= 0;
            regWriteCount <= 0;
            mdrCount <= 0;
            condCount <= 0;
            issued <= 0;
            haltIdle <= 0;
        end
        else if (ctrl.irWrite)
        begin
            // the word just latched is presented as the decoded instruction
            if (issued < NumInsts)
            begin
                opcode <= kindOp[progKind[issued]];
                func <= kindFn[progKind[issued]];
                curCls <= kindCls[progKind[issued]];
                curAluOp <= kindAlu[progKind[issued]];
            end
            issued <= issued + 1;
            awaitPcInc <= 1'b1;
            aluOutCount <= 0;
            regWriteCount <= 0;
            mdrCount <= 0;
            condCount <= 0;
        end
        else
        begin
            if (ctrl.pcWrite)
                awaitPcInc <= 1'b0;
            if (memReq && memAck)
                dataPending <= 1'b0;
            else if (ctrl.aluOutWrite && aluOutCount == 1 &&
                     (curCls == cpuCtrlPkg::ClsLoad || curCls == cpuCtrlPkg::ClsStore))
                dataPending <= 1'b1; // execute done, memory stage next
            aluOutCount <= aluOutCount + int'(ctrl.aluOutWrite);
            regWriteCount <= regWriteCount + int'(ctrl.regWrite);
            mdrCount <= mdrCount + int'(ctrl.mdrWrite);
            condCount <= condCount + int'(ctrl.pcWriteCond);
            if (curCls == cpuCtrlPkg::ClsHalt && aluOutCount == 1)
                haltIdle <= haltIdle + 1; // parked after decode
        end
    end

    initial
    begin
        void'($urandom(58));
        fillKindTable();
        composeProgram();
        rst = 1'b1;
        memAck = 1'b0;
        opcode = cpuCtrlPkg::OpAlu;
        func = cpuCtrlPkg::FnWwd;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        while (haltIdle < HaltWatchCycles && cycleCount < TimeoutCycles)
            @(posedge clk);
        if (cycleCount >= TimeoutCycles)
            reportFailure("timeout: the control unit did not reach the halted state in time");
        else if (issued != NumInsts)
            reportFailure($sformatf("halted after %0d of %0d instructions", issued, NumInsts));
        else
        begin
            $display("test passed");
            $finish;
        end
    end

    `include "cpuControlChecks.svh"

endmodule

`default_nettype wire

// ==== cpuControl.f ====
+incdir+testbench
design/cpuCtrlPkg.sv
design/instDecoder.sv
design/stageSequencer.sv
design/ctrlSignalGen.sv
design/cpuControl.sv
testbench/cpuControlTb.sv
